//--- rib_cfg.svh
`ifndef RIB_CFG_SVH
`define RIB_CFG_SVH

// bus widths
`define RIB_ADDR_W 32
`define RIB_DATA_W 32

// word ram size
`define RAM_DEPTH 256

// region codes, taken from addr[31:28]
`define REGION_W     4
`define REGION_RAM   4'h0
`define REGION_TIMER 4'h1

`endif

//--- rib_pkg.sv
`default_nettype none

`include "rib_cfg.svh"

package rib_pkg;

    // payload types shared by every bus port
    typedef logic [`RIB_ADDR_W-1:0] addr_t;
    typedef logic [`RIB_DATA_W-1:0] data_t;
    typedef logic [`REGION_W-1:0]   region_t;

    // owner of the bus in the current cycle
    typedef enum logic [1:0] {
        GRANT_NONE = 2'd0,
        GRANT_CORE = 2'd1,
        GRANT_DBG  = 2'd2
    } grant_e;

    // decoded target of the winning access
    typedef enum logic [1:0] {
        SEL_RAM   = 2'd0,
        SEL_TIMER = 2'd1,
        SEL_NONE  = 2'd2
    } slave_e;

endpackage

`default_nettype wire

//--- periph_pkg.sv
`default_nettype none

package periph_pkg;

    // word offsets inside the timer region, from addr[3:2]
    typedef enum logic [1:0] {
        REG_CTRL  = 2'd0,
        REG_COUNT = 2'd1,
        REG_VALUE = 2'd2
    } timer_reg_e;

    // ctrl register bit positions
    localparam int unsigned CTRL_EN     = 0;
    localparam int unsigned CTRL_INT_EN = 1;
    // write 1 to clear
    localparam int unsigned CTRL_PEND   = 2;

    // number of implemented ctrl bits
    localparam int unsigned CTRL_W      = 3;

endpackage

`default_nettype wire

//--- rib_if.sv
`timescale 1ns/1ns
`default_nettype none

interface rib_if;

    logic            req;
    logic            we;
    rib_pkg::addr_t  addr;
    rib_pkg::data_t  wdata;
    rib_pkg::data_t  rdata;
    logic            ready;

    // side that starts an access
    modport master (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  ready
    );

    // side that answers an access
    modport slave (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output ready
    );

endinterface

`default_nettype wire

//--- rib.sv
`timescale 1ns/1ns
`default_nettype none

`include "rib_cfg.svh"

module rib (
    rib_if.slave  m_core_i,
    rib_if.slave  m_dbg_i,
    rib_if.master s_ram_o,
    rib_if.master s_timer_o,
    output logic  hold_o
);

    rib_pkg::grant_e  grant;
    rib_pkg::slave_e  sel;
    rib_pkg::region_t region;

    logic             bus_req;
    logic             bus_we;
    rib_pkg::addr_t   bus_addr;
    rib_pkg::data_t   bus_wdata;
    rib_pkg::data_t   bus_rdata;
    logic             bus_ready;

    // fixed priority, debug wins
    always_comb begin
        if (m_dbg_i.req) begin
            grant = rib_pkg::GRANT_DBG;
        end else if (m_core_i.req) begin
            grant = rib_pkg::GRANT_CORE;
        end else begin
            grant = rib_pkg::GRANT_NONE;
        end
    end

    // core waits while debug owns the bus
    assign hold_o = m_core_i.req & m_dbg_i.req;

    // forward the winner
    always_comb begin
        bus_req   = 1'b0;
        bus_we    = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        case (grant)
            rib_pkg::GRANT_DBG: begin
                bus_req   = 1'b1;
                bus_we    = m_dbg_i.we;
                bus_addr  = m_dbg_i.addr;
                bus_wdata = m_dbg_i.wdata;
            end
            rib_pkg::GRANT_CORE: begin
                bus_req   = 1'b1;
                bus_we    = m_core_i.we;
                bus_addr  = m_core_i.addr;
                bus_wdata = m_core_i.wdata;
            end
            default: begin
            end
        endcase
    end

    // address decode on the top nibble
    assign region = bus_addr[`RIB_ADDR_W-1 -: `REGION_W];

    always_comb begin
        case (region)
            `REGION_RAM:   sel = rib_pkg::SEL_RAM;
            `REGION_TIMER: sel = rib_pkg::SEL_TIMER;
            default:       sel = rib_pkg::SEL_NONE;
        endcase
    end

    // addr, we and wdata broadcast, req only to the target
    assign s_ram_o.req     = bus_req & (sel == rib_pkg::SEL_RAM);
    assign s_ram_o.we      = bus_we;
    assign s_ram_o.addr    = bus_addr;
    assign s_ram_o.wdata   = bus_wdata;

    assign s_timer_o.req   = bus_req & (sel == rib_pkg::SEL_TIMER);
    assign s_timer_o.we    = bus_we;
    assign s_timer_o.addr  = bus_addr;
    assign s_timer_o.wdata = bus_wdata;

    // read return, unmapped reads give zero and complete at once
    always_comb begin
        case (sel)
            rib_pkg::SEL_RAM: begin
                bus_rdata = s_ram_o.rdata;
                bus_ready = s_ram_o.ready;
            end
            rib_pkg::SEL_TIMER: begin
                bus_rdata = s_timer_o.rdata;
                bus_ready = s_timer_o.ready;
            end
            default: begin
                bus_rdata = '0;
                bus_ready = bus_req;
            end
        endcase
    end

    // answer only the winner
    assign m_dbg_i.ready  = (grant == rib_pkg::GRANT_DBG) & bus_ready;
    assign m_dbg_i.rdata  = (grant == rib_pkg::GRANT_DBG) ? bus_rdata : '0;
    assign m_core_i.ready = (grant == rib_pkg::GRANT_CORE) & bus_ready;
    assign m_core_i.rdata = (grant == rib_pkg::GRANT_CORE) ? bus_rdata : '0;

endmodule

`default_nettype wire

//--- ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "rib_cfg.svh"

module ram (
    input  logic  clk_i,
    rib_if.slave  bus_i
);

    localparam int unsigned IDX_W = $clog2(`RAM_DEPTH);

    rib_pkg::data_t   mem [`RAM_DEPTH];
    logic [IDX_W-1:0] idx;

    // word index, byte offset dropped
    assign idx = bus_i.addr[IDX_W+1:2];

    always_ff @(posedge clk_i) begin
        if (bus_i.req && bus_i.we) begin
            mem[idx] <= bus_i.wdata;
        end
    end

    // async read
    assign bus_i.rdata = mem[idx];

    // zero wait states
    assign bus_i.ready = bus_i.req;

endmodule

`default_nettype wire

//--- timer.sv
`timescale 1ns/1ns
`default_nettype none

module timer (
    input  logic  clk_i,
    input  logic  rst_n_i,
    rib_if.slave  bus_i,
    output logic  irq_o
);

    periph_pkg::timer_reg_e reg_sel;

    logic           ctrl_en;
    logic           ctrl_int_en;
    logic           pend;
    rib_pkg::data_t count;
    rib_pkg::data_t value;

    logic           wr;
    logic           hit;

    assign reg_sel = periph_pkg::timer_reg_e'(bus_i.addr[3:2]);
    assign wr      = bus_i.req & bus_i.we;

    // compare match while running
    assign hit = ctrl_en & (count == value);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_en     <= 1'b0;
            ctrl_int_en <= 1'b0;
            pend        <= 1'b0;
            count       <= '0;
            value       <= '0;
        end else begin
            if (hit) begin
                count <= '0;
                pend  <= 1'b1;
            end else if (ctrl_en) begin
                count <= count + 1'b1;
            end

            // bus writes override the counter
            if (wr) begin
                case (reg_sel)
                    periph_pkg::REG_CTRL: begin
                        ctrl_en     <= bus_i.wdata[periph_pkg::CTRL_EN];
                        ctrl_int_en <= bus_i.wdata[periph_pkg::CTRL_INT_EN];
                        if (bus_i.wdata[periph_pkg::CTRL_PEND]) begin
                            pend <= 1'b0;
                        end
                    end
                    periph_pkg::REG_COUNT: count <= bus_i.wdata;
                    periph_pkg::REG_VALUE: value <= bus_i.wdata;
                    default: begin
                    end
                endcase
            end
        end
    end

    // register read, offset 3 reads zero
    always_comb begin
        bus_i.rdata = '0;
        case (reg_sel)
            periph_pkg::REG_CTRL: begin
                bus_i.rdata[periph_pkg::CTRL_EN]     = ctrl_en;
                bus_i.rdata[periph_pkg::CTRL_INT_EN] = ctrl_int_en;
                bus_i.rdata[periph_pkg::CTRL_PEND]   = pend;
            end
            periph_pkg::REG_COUNT: bus_i.rdata = count;
            periph_pkg::REG_VALUE: bus_i.rdata = value;
            default: begin
            end
        endcase
    end

    assign bus_i.ready = bus_i.req;

    assign irq_o = pend & ctrl_int_en;

endmodule

`default_nettype wire

//--- soc_bus_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "rib_cfg.svh"

module soc_bus_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // core data port
    input  logic                  core_req_i,
    input  logic                  core_we_i,
    input  logic [`RIB_ADDR_W-1:0] core_addr_i,
    input  logic [`RIB_DATA_W-1:0] core_wdata_i,
    output logic [`RIB_DATA_W-1:0] core_rdata_o,
    output logic                  core_ready_o,
    output logic                  core_hold_o,

    // debug port
    input  logic                  dbg_req_i,
    input  logic                  dbg_we_i,
    input  logic [`RIB_ADDR_W-1:0] dbg_addr_i,
    input  logic [`RIB_DATA_W-1:0] dbg_wdata_i,
    output logic [`RIB_DATA_W-1:0] dbg_rdata_o,
    output logic                  dbg_ready_o,

    output logic                  timer_irq_o
);

    rib_if m_core ();
    rib_if m_dbg ();
    rib_if s_ram ();
    rib_if s_timer ();

    // plain ports onto the master buses
    assign m_core.req    = core_req_i;
    assign m_core.we     = core_we_i;
    assign m_core.addr   = core_addr_i;
    assign m_core.wdata  = core_wdata_i;
    assign core_rdata_o  = m_core.rdata;
    assign core_ready_o  = m_core.ready;

    assign m_dbg.req     = dbg_req_i;
    assign m_dbg.we      = dbg_we_i;
    assign m_dbg.addr    = dbg_addr_i;
    assign m_dbg.wdata   = dbg_wdata_i;
    assign dbg_rdata_o   = m_dbg.rdata;
    assign dbg_ready_o   = m_dbg.ready;

    rib u_rib (
        .m_core_i (m_core),
        .m_dbg_i  (m_dbg),
        .s_ram_o  (s_ram),
        .s_timer_o(s_timer),
        .hold_o   (core_hold_o)
    );

    ram u_ram (
        .clk_i(clk_i),
        .bus_i(s_ram)
    );

    timer u_timer (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .bus_i  (s_timer),
        .irq_o  (timer_irq_o)
    );

endmodule

`default_nettype wire

//--- tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    // 8 ns period
    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

    always #4 clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- soc_bus_assertions.sv
`timescale 1ns/1ns
`default_nettype none

`include "rib_cfg.svh"

module soc_bus_assertions (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   core_req_i,
    input logic                   core_we_i,
    input logic [`RIB_ADDR_W-1:0] core_addr_i,
    input logic [`RIB_DATA_W-1:0] core_wdata_i,
    input logic [`RIB_DATA_W-1:0] core_rdata_i,
    input logic                   core_ready_i,
    input logic                   core_hold_i,
    input logic                   dbg_req_i,
    input logic                   dbg_we_i,
    input logic [`RIB_ADDR_W-1:0] dbg_addr_i,
    input logic [`RIB_DATA_W-1:0] dbg_wdata_i,
    input logic [`RIB_DATA_W-1:0] dbg_rdata_i,
    input logic                   dbg_ready_i,
    input logic                   timer_irq_i,
    input logic                   ram_req_i,
    input logic                   tmr_pend_i,
    input logic [`RIB_DATA_W-1:0] tmr_count_i
);

    int unsigned fail_cnt = 0;

    logic             win_req;
    logic             win_we;
    rib_pkg::addr_t   win_addr;
    rib_pkg::data_t   win_wdata;
    rib_pkg::data_t   win_rdata;
    rib_pkg::slave_e  tgt;
    logic [7:0]       idx;
    logic             pend_clr;

    // shadow of ram words and timer settings
    rib_pkg::data_t          shadow [`RAM_DEPTH];
    logic [`RAM_DEPTH-1:0]   shadow_vld;
    rib_pkg::data_t          exp_rdata;
    logic                    exp_vld;
    logic                    sh_en;
    logic                    sh_int_en;
    rib_pkg::data_t          sh_value;

    // debug wins whenever it asks
    assign win_req   = dbg_req_i | core_req_i;
    assign win_we    = dbg_req_i ? dbg_we_i : core_we_i;
    assign win_addr  = dbg_req_i ? dbg_addr_i : core_addr_i;
    assign win_wdata = dbg_req_i ? dbg_wdata_i : core_wdata_i;
    assign win_rdata = dbg_req_i ? dbg_rdata_i : core_rdata_i;
    assign idx       = win_addr[9:2];
    assign exp_rdata = shadow[idx];
    assign exp_vld   = shadow_vld[idx];

    always_comb begin
        case (win_addr[31:28])
            `REGION_RAM:   tgt = rib_pkg::SEL_RAM;
            `REGION_TIMER: tgt = rib_pkg::SEL_TIMER;
            default:       tgt = rib_pkg::SEL_NONE;
        endcase
    end

    assign pend_clr = win_req & win_we & (tgt == rib_pkg::SEL_TIMER)
                    & (win_addr[3:2] == periph_pkg::REG_CTRL)
                    & win_wdata[periph_pkg::CTRL_PEND];

    always_ff @(posedge clk_i) begin
        if (win_req && win_we && tgt == rib_pkg::SEL_RAM) begin
            shadow[idx] <= win_wdata;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            shadow_vld <= '0;
            sh_en      <= 1'b0;
            sh_int_en  <= 1'b0;
            sh_value   <= '0;
        end else if (win_req && win_we) begin
            if (tgt == rib_pkg::SEL_RAM) begin
                shadow_vld[idx] <= 1'b1;
            end else if (tgt == rib_pkg::SEL_TIMER) begin
                if (win_addr[3:2] == periph_pkg::REG_CTRL) begin
                    sh_en     <= win_wdata[periph_pkg::CTRL_EN];
                    sh_int_en <= win_wdata[periph_pkg::CTRL_INT_EN];
                end else if (win_addr[3:2] == periph_pkg::REG_VALUE) begin
                    sh_value <= win_wdata;
                end
            end
        end
    end

    task flag_failure(input string msg);
        $error("%s", msg);
        fail_cnt++;
    endtask

    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |-> !core_ready_i && !dbg_ready_i && !core_hold_i && !timer_irq_i)
        else flag_failure("outputs active during reset");

    a_dbg_priority: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_req_i && dbg_req_i |-> dbg_ready_i && !core_ready_i && core_hold_i)
        else flag_failure("debug master did not win the bus");

    a_one_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        win_req |-> $onehot({core_ready_i, dbg_ready_i}))
        else flag_failure("ready not given to exactly one master");

    a_ram_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        win_req && !win_we && tgt == rib_pkg::SEL_RAM && exp_vld |-> win_rdata == exp_rdata)
        else flag_failure("ram read differs from last write");

    a_unmapped_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        win_req && !win_we && tgt == rib_pkg::SEL_NONE |-> win_rdata == '0)
        else flag_failure("unmapped read is not zero");

    a_unmapped_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        win_req && tgt == rib_pkg::SEL_NONE |-> !ram_req_i)
        else flag_failure("unmapped access reached the ram");

    a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        win_req && !win_we && tgt == rib_pkg::SEL_TIMER && sh_en
        && win_addr[3:2] == periph_pkg::REG_COUNT |-> sh_value >= win_rdata)
        else flag_failure("timer count above compare value");

    // compare hit must leave pending set
    a_wrap_pend: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        sh_en && tmr_count_i == sh_value && !pend_clr |=> tmr_pend_i)
        else flag_failure("pending not set after wrap");

    a_irq_follow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        timer_irq_i == (tmr_pend_i && sh_int_en))
        else flag_failure("irq does not follow pending and enable");

    a_pend_clear: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pend_clr |=> !timer_irq_i)
        else flag_failure("irq still high after pending clear");

endmodule

bind soc_bus_top soc_bus_assertions u_checks (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .core_req_i  (core_req_i),
    .core_we_i   (core_we_i),
    .core_addr_i (core_addr_i),
    .core_wdata_i(core_wdata_i),
    .core_rdata_i(core_rdata_o),
    .core_ready_i(core_ready_o),
    .core_hold_i (core_hold_o),
    .dbg_req_i   (dbg_req_i),
    .dbg_we_i    (dbg_we_i),
    .dbg_addr_i  (dbg_addr_i),
    .dbg_wdata_i (dbg_wdata_i),
    .dbg_rdata_i (dbg_rdata_o),
    .dbg_ready_i (dbg_ready_o),
    .timer_irq_i (timer_irq_o),
    .ram_req_i   (s_ram.req),
    .tmr_pend_i  (u_timer.pend),
    .tmr_count_i (u_timer.count)
);

`default_nettype wire

//--- tb_soc_bus.sv
`timescale 1ns/1ns
`default_nettype none

`include "rib_cfg.svh"

module tb_soc_bus;

    localparam int unsigned MAX_CYCLES  = 4000;
    localparam int unsigned RAND_CYCLES = 1900;
    localparam logic [31:0] TMR_CTRL    = 32'h1000_0000;
    localparam logic [31:0] TMR_COUNT   = 32'h1000_0004;
    localparam logic [31:0] TMR_VALUE   = 32'h1000_0008;

    logic                   clk;
    logic                   rst_n;
    logic                   core_req;
    logic                   core_we;
    logic [`RIB_ADDR_W-1:0] core_addr;
    logic [`RIB_DATA_W-1:0] core_wdata;
    logic [`RIB_DATA_W-1:0] core_rdata;
    logic                   core_ready;
    logic                   core_hold;
    logic                   dbg_req;
    logic                   dbg_we;
    logic [`RIB_ADDR_W-1:0] dbg_addr;
    logic [`RIB_DATA_W-1:0] dbg_wdata;
    logic [`RIB_DATA_W-1:0] dbg_rdata;
    logic                   dbg_ready;
    logic                   timer_irq;
    logic [31:0]            rnd;
    int unsigned            cycles = 0;

    tb_clkgen u_clkgen (
        .clk_o  (clk),
        .rst_n_o(rst_n)
    );

    soc_bus_top i_dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .core_req_i  (core_req),
        .core_we_i   (core_we),
        .core_addr_i (core_addr),
        .core_wdata_i(core_wdata),
        .core_rdata_o(core_rdata),
        .core_ready_o(core_ready),
        .core_hold_o (core_hold),
        .dbg_req_i   (dbg_req),
        .dbg_we_i    (dbg_we),
        .dbg_addr_i  (dbg_addr),
        .dbg_wdata_i (dbg_wdata),
        .dbg_rdata_o (dbg_rdata),
        .dbg_ready_o (dbg_ready),
        .timer_irq_o (timer_irq)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ram words 0..31, a quarter of the time regions 2..9
    function automatic logic [31:0] pick_addr(input logic [31:0] r);
        logic [3:0] region;
        region = (r[1:0] == 2'd0) ? (4'h2 + {1'b0, r[4:2]}) : `REGION_RAM;
        return {region, 21'd0, r[9:5], 2'b00};
    endfunction

    task automatic core_access(
        input logic        we,
        input logic [31:0] addr,
        input logic [31:0] wdata
    );
        @(posedge clk);
        core_req   <= 1'b1;
        core_we    <= we;
        core_addr  <= addr;
        core_wdata <= wdata;
        do begin
            @(posedge clk);
        end while (!core_ready);
        core_req <= 1'b0;
    endtask

    // first checker failure or runaway run
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (i_dut.u_checks.fail_cnt != 0) begin
            $display("ERROR at %0t ns: bus checker reported %0d failure(s)",
                     $time, i_dut.u_checks.fail_cnt);
            $display("CHECKS FAILED");
            $fatal(1);
        end else if (cycles >= MAX_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    initial begin
        core_req   = 1'b0;
        core_we    = 1'b0;
        core_addr  = '0;
        core_wdata = '0;
        dbg_req    = 1'b0;
        dbg_we     = 1'b0;
        dbg_addr   = '0;
        dbg_wdata  = '0;
        rnd        = 32'd62;
        @(posedge rst_n);
        repeat (2) @(posedge clk);

        // random traffic, a master keeps its access until ready
        for (int i = 0; i < RAND_CYCLES; i++) begin
            @(posedge clk);
            if (!core_req || core_ready) begin
                rnd = xorshift(rnd);
                core_req  <= rnd[0] | rnd[1];
                core_we   <= rnd[2];
                core_addr <= pick_addr(rnd >> 3);
                rnd = xorshift(rnd);
                core_wdata <= rnd;
            end
            if (!dbg_req || dbg_ready) begin
                rnd = xorshift(rnd);
                dbg_req  <= (rnd[1:0] == 2'd0);
                dbg_we   <= rnd[2];
                dbg_addr <= pick_addr(rnd >> 3);
                rnd = xorshift(rnd);
                dbg_wdata <= rnd;
            end
        end
        // a held core access still has to finish
        @(posedge clk);
        dbg_req <= 1'b0;
        while (core_req && !core_ready) begin
            @(posedge clk);
        end
        core_req <= 1'b0;

        // compare at 20 with en and int_en, poll until the irq
        core_access(1'b1, TMR_VALUE, 32'd20);
        core_access(1'b1, TMR_CTRL, 32'h3);
        while (!timer_irq) begin
            core_access(1'b0, TMR_COUNT, 32'd0);
        end
        // pending bit written back as 1
        core_access(1'b1, TMR_CTRL, 32'h7);
        repeat (4) core_access(1'b0, TMR_COUNT, 32'd0);
        core_access(1'b1, TMR_CTRL, 32'h0);
        repeat (4) @(posedge clk);

        if (i_dut.u_checks.fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
rib_pkg.sv
periph_pkg.sv
rib_if.sv
rib.sv
ram.sv
timer.sv
soc_bus_top.sv
tb_clkgen.sv
soc_bus_assertions.sv
tb_soc_bus.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log \
    && verilator --binary --timing --assert --top-module tb_soc_bus -f files.f \
    && { ./obj_dir/Vtb_soc_bus +verilator+error+limit+100 > sim.log 2>&1 || true; } \
    && grep -q "^ALL CHECKS PASSED$" sim.log \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail, see sim.log"; exit 1; }
